/* rtl/rvPkg.sv */
`default_nettype none

package rvPkg;

   // Major opcode, instruction bits 6..2
   typedef enum logic [4:0] {
      LOAD   = 5'b00000,
      NOP    = 5'b00010,
      OPIMM  = 5'b00100,
      AUIPC  = 5'b00101,
      STORE  = 5'b01000,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      BRANCH = 5'b11000,
      JALR   = 5'b11001,
      JAL    = 5'b11011
   } opcodeT;

   // Top bit is instruction bit 30, low bits are funct3
   typedef enum logic [3:0] {
      ADD   = 4'b0000,
      SLL   = 4'b0001,
      SLT   = 4'b0010,
      SLTU  = 4'b0011,
      XOR   = 4'b0100,
      SRL   = 4'b0101,
      OR    = 4'b0110,
      AND   = 4'b0111,
      SUB   = 4'b1000,
      PASSB = 4'b1001,
      SRA   = 4'b1101
   } aluOpT;

   typedef enum logic [2:0] {
      NONE = 3'd0,
      I    = 3'd1,
      S    = 3'd2,
      B    = 3'd3,
      U    = 3'd4,
      J    = 3'd5
   } immTypeT;

   typedef enum logic [1:0] {
      PLUS4  = 2'd0,
      TARGET = 2'd1,
      HOLD   = 2'd2
   } pcSelT;

   typedef enum logic [1:0] {
      MEM = 2'd0,
      ALU = 2'd1,
      PC4 = 2'd2
   } wbSelT;

   // Execute stage controls
   typedef struct packed {
      logic    aSel;
      logic    bSel;
      aluOpT   aluOp;
      logic    brUn;
      logic [1:0] storeSize;
   } exCtrlT;

   // Writeback stage controls
   typedef struct packed {
      logic       regWrEn;
      wbSelT      wbSel;
      logic [2:0] loadFunct3;
   } wbCtrlT;

   // Writeback result forwarded into decode (fa1, fb1) and execute (fa2, fb2)
   typedef struct packed {
      logic fa1;
      logic fb1;
      logic fa2;
      logic fb2;
   } fwdT;

   typedef struct packed {
      logic [31:0] addr;
   } axiAwT;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  strb;
   } axiWT;

   localparam logic [3:0]  ioRegion = 4'h8;
   localparam logic [31:0] nopInst  = 32'h0000_0013;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
   input  wire         clk,
   input  wire  [4:0]  rs1,
   input  wire  [4:0]  rs2,
   input  wire  [4:0]  rd,
   input  wire         we,
   input  wire  [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [32];

   always_ff @(posedge clk) begin
      if (we && rd != 5'd0) begin
         regs[rd] <= wd;
      end
   end

   assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
   assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

   // A read returns last edge's write, and x0 stays zero even when written
   readAfterWrite: assert property (@(posedge clk)
      $past(we) && (rs1 == $past(rd))
      |-> rd1 == (($past(rd) == 5'd0) ? 32'd0 : $past(wd)));

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit (
   input  wire [31:0]           exInst,
   input  wire [31:0]           pc,
   input  wire [31:0]           rs1Val,
   input  wire [31:0]           rs2Val,
   input  wire [31:0]           wbVal,
   input  wire rvPkg::exCtrlT   exCtrl,
   input  wire rvPkg::immTypeT  immType,
   input  wire rvPkg::fwdT      fwd,
   output logic [31:0]          aluOut,
   output logic [31:0]          storeData,
   output logic                 brEq,
   output logic                 brLt
);

   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] imm;
   logic [31:0] aIn;
   logic [31:0] bIn;
   logic [4:0]  shamt;

   assign opA = fwd.fa2 ? wbVal : rs1Val;
   assign opB = fwd.fb2 ? wbVal : rs2Val;

   always_comb begin
      case (immType)
         rvPkg::I: imm = {{20{exInst[31]}}, exInst[31:20]};
         rvPkg::S: imm = {{20{exInst[31]}}, exInst[31:25], exInst[11:7]};
         rvPkg::B: imm = {{19{exInst[31]}}, exInst[31], exInst[7], exInst[30:25],
                          exInst[11:8], 1'b0};
         rvPkg::U: imm = {exInst[31:12], 12'd0};
         rvPkg::J: imm = {{11{exInst[31]}}, exInst[31], exInst[19:12], exInst[20],
                          exInst[30:21], 1'b0};
         default:  imm = 32'd0;
      endcase
   end

   assign aIn   = exCtrl.aSel ? pc : opA;
   assign bIn   = exCtrl.bSel ? imm : opB;
   assign shamt = bIn[4:0];

   always_comb begin
      case (exCtrl.aluOp)
         rvPkg::ADD:  aluOut = aIn + bIn;
         rvPkg::SUB:  aluOut = aIn - bIn;
         rvPkg::SLL:  aluOut = aIn << shamt;
         rvPkg::SLT:  aluOut = {31'd0, $signed(aIn) < $signed(bIn)};
         rvPkg::SLTU: aluOut = {31'd0, aIn < bIn};
         rvPkg::XOR:  aluOut = aIn ^ bIn;
         rvPkg::SRL:  aluOut = aIn >> shamt;
         rvPkg::SRA:  aluOut = $unsigned($signed(aIn) >>> shamt);
         rvPkg::OR:   aluOut = aIn | bIn;
         rvPkg::AND:  aluOut = aIn & bIn;
         default:     aluOut = bIn;
      endcase
   end

   // Narrow stores repeat the value on every byte lane
   always_comb begin
      case (exCtrl.storeSize)
         2'b00:   storeData = {4{opB[7:0]}};
         2'b01:   storeData = {2{opB[15:0]}};
         default: storeData = opB;
      endcase
   end

   assign brEq = (opA == opB);
   assign brLt = exCtrl.brUn ? (opA < opB) : ($signed(opA) < $signed(opB));

endmodule

`default_nettype wire

/* rtl/pipeControl.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeControl #(
   parameter logic [31:0] resetPc = 32'h0
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  stall,
   input  wire [31:0]           inst,
   input  wire                  brEq,
   input  wire                  brLt,
   input  wire [31:0]           exAddr,
   output rvPkg::immTypeT       immType,
   output rvPkg::exCtrlT        exCtrl,
   output rvPkg::wbCtrlT        wbCtrl,
   output rvPkg::fwdT           fwd,
   output rvPkg::pcSelT         pcSel,
   output logic                 injectNop,
   output logic                 dramWe,
   output logic                 ioStore
);

   // Empty slot left in the pipeline by reset
   localparam logic [31:0] emptySlot = {25'd0, rvPkg::NOP, 2'b11};

   // Data RAM answers in the 256 MB region of the reset vector
   localparam logic [3:0] memRegion = resetPc[31:28];

   logic [31:0]    exInst;
   logic [31:0]    wbInst;
   logic [4:0]     wbRd;
   logic           wbWrites;
   logic           taken;
   logic           isStore;
   rvPkg::opcodeT  exOp;
   rvPkg::opcodeT  wbOp;
   rvPkg::immTypeT decImm;

   function automatic logic readsRs1(input logic [4:0] op);
      case (op)
         rvPkg::LUI, rvPkg::AUIPC, rvPkg::JAL, rvPkg::NOP: readsRs1 = 1'b0;
         default: readsRs1 = 1'b1;
      endcase
   endfunction

   function automatic logic readsRs2(input logic [4:0] op);
      readsRs2 = (op == rvPkg::OP) || (op == rvPkg::STORE) || (op == rvPkg::BRANCH);
   endfunction

   assign exOp = rvPkg::opcodeT'(exInst[6:2]);
   assign wbOp = rvPkg::opcodeT'(wbInst[6:2]);
   assign wbRd = wbInst[11:7];

   always_ff @(posedge clk) begin
      if (rst) begin
         exInst  <= emptySlot;
         wbInst  <= emptySlot;
         immType <= rvPkg::NONE;
      end else if (!stall) begin
         // A taken branch in execute kills the instruction being fetched
         exInst  <= injectNop ? rvPkg::nopInst : inst;
         immType <= injectNop ? rvPkg::NONE : decImm;
         wbInst  <= exInst;
      end
   end

   always_comb begin
      case (inst[6:2])
         rvPkg::LOAD, rvPkg::JALR, rvPkg::OPIMM: decImm = rvPkg::I;
         rvPkg::STORE:                           decImm = rvPkg::S;
         rvPkg::BRANCH:                          decImm = rvPkg::B;
         rvPkg::AUIPC, rvPkg::LUI:               decImm = rvPkg::U;
         rvPkg::JAL:                             decImm = rvPkg::J;
         default:                                decImm = rvPkg::NONE;
      endcase
   end

   always_comb begin
      exCtrl = '{aSel: 1'b0, bSel: 1'b1, aluOp: rvPkg::ADD, brUn: 1'b0, storeSize: 2'b10};
      case (exOp)
         rvPkg::STORE: exCtrl.storeSize = exInst[13:12];
         rvPkg::BRANCH: begin
            exCtrl.aSel = 1'b1;
            exCtrl.brUn = exInst[13];
         end
         rvPkg::JAL, rvPkg::AUIPC: exCtrl.aSel = 1'b1;
         rvPkg::OP: begin
            exCtrl.bSel  = 1'b0;
            exCtrl.aluOp = rvPkg::aluOpT'({exInst[30], exInst[14:12]});
         end
         rvPkg::OPIMM: begin
            // Bit 30 belongs to the immediate except for shifts
            if (exInst[13:12] == 2'b01) begin
               exCtrl.aluOp = rvPkg::aluOpT'({exInst[30], exInst[14:12]});
            end else begin
               exCtrl.aluOp = rvPkg::aluOpT'({1'b0, exInst[14:12]});
            end
         end
         rvPkg::LUI: exCtrl.aluOp = rvPkg::PASSB;
         default: ;
      endcase
   end

   // funct3 bit 2 picks less-than over equal, bit 0 inverts
   assign taken = exInst[14] ? (brLt ^ exInst[12]) : (brEq ^ exInst[12]);

   always_comb begin
      if (exOp == rvPkg::JAL || exOp == rvPkg::JALR || (exOp == rvPkg::BRANCH && taken)) begin
         pcSel = rvPkg::TARGET;
      end else begin
         pcSel = rvPkg::PLUS4;
      end
   end

   assign injectNop = (pcSel == rvPkg::TARGET);

   assign isStore = (exOp == rvPkg::STORE);
   assign dramWe  = isStore && (exAddr[31:28] == memRegion);
   assign ioStore = isStore && (exAddr[31:28] == rvPkg::ioRegion);

   always_comb begin
      wbCtrl = '{regWrEn: 1'b0, wbSel: rvPkg::ALU, loadFunct3: wbInst[14:12]};
      case (wbOp)
         rvPkg::LOAD: begin
            wbCtrl.regWrEn = 1'b1;
            wbCtrl.wbSel   = rvPkg::MEM;
         end
         rvPkg::JAL, rvPkg::JALR: begin
            wbCtrl.regWrEn = 1'b1;
            wbCtrl.wbSel   = rvPkg::PC4;
         end
         rvPkg::OP, rvPkg::OPIMM, rvPkg::AUIPC, rvPkg::LUI: wbCtrl.regWrEn = 1'b1;
         default: ;
      endcase
   end

   // x0 never forwards
   assign wbWrites = wbCtrl.regWrEn && (wbRd != 5'd0);

   always_comb begin
      fwd.fa1 = wbWrites && readsRs1(inst[6:2]) && (inst[19:15] == wbRd);
      fwd.fb1 = wbWrites && readsRs2(inst[6:2]) && (inst[24:20] == wbRd);
      fwd.fa2 = wbWrites && readsRs1(exInst[6:2]) && (exInst[19:15] == wbRd);
      fwd.fb2 = wbWrites && readsRs2(exInst[6:2]) && (exInst[24:20] == wbRd);
   end

   // Stalls freeze the PC through its enable, so the select never holds
   pcHoldOnlyInReset: assert property (@(posedge clk) (pcSel == rvPkg::HOLD) |-> rst);

endmodule

`default_nettype wire

/* rtl/mmioWriteBridge.sv */
`timescale 1ns/10ps
`default_nettype none

module mmioWriteBridge (
   input  wire          clk,
   input  wire          rst,
   input  wire          ioStore,
   input  wire  [31:0]  addr,
   input  wire  [31:0]  data,
   input  wire  [3:0]   strb,
   input  wire          awready,
   input  wire          wready,
   input  wire          bvalid,
   input  wire  [1:0]   bresp,
   output rvPkg::axiAwT aw,
   output logic         awvalid,
   output rvPkg::axiWT  w,
   output logic         wvalid,
   output logic         bready,
   output logic         stall
);

   typedef enum logic [1:0] {stIdle, stSend, stResp} stateT;

   stateT state;
   logic  awDone;
   logic  wDone;

   // Channel finished, or finishing this cycle
   assign awDone = !awvalid || awready;
   assign wDone  = !wvalid || wready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= stIdle;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               if (ioStore) begin
                  awvalid <= 1'b1;
                  wvalid  <= 1'b1;
                  state   <= stSend;
               end
            end
            stSend: begin
               if (awready) begin
                  awvalid <= 1'b0;
               end
               if (wready) begin
                  wvalid <= 1'b0;
               end
               if (awDone && wDone) begin
                  state <= stResp;
               end
            end
            default: begin
               if (bvalid) begin
                  state <= stIdle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == stIdle && ioStore) begin
         aw.addr <= addr;
         w.data  <= data;
         w.strb  <= strb;
      end
   end

   assign bready = (state == stResp);

   // Released in the cycle the response handshake completes
   assign stall = (state == stIdle && ioStore) || (state == stSend) ||
                  (state == stResp && !bvalid);

   awStable: assert property (@(posedge clk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(aw));

   wStable: assert property (@(posedge clk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(w));

   // I/O devices never refuse a write
   respOkay: assert property (@(posedge clk) disable iff (rst)
      bvalid && bready |-> bresp == 2'b00);

endmodule

`default_nettype wire

/* rtl/rvCore.sv */
`timescale 1ns/10ps
`default_nettype none

module rvCore #(
   parameter logic [31:0] resetPc      = 32'h0,
   parameter int          dataRamWords = 256
) (
   input  wire          clk,
   input  wire          rst,
   input  wire  [31:0]  inst,
   output logic [31:0]  pc,
   output rvPkg::axiAwT aw,
   output logic         awvalid,
   input  wire          awready,
   output rvPkg::axiWT  w,
   output logic         wvalid,
   input  wire          wready,
   input  wire          bvalid,
   input  wire  [1:0]   bresp,
   output logic         bready
);

   localparam int ramIdxW = $clog2(dataRamWords);

   logic                stall;
   logic                injectNop;
   logic                dramWe;
   logic                ioStore;
   logic                brEq;
   logic                brLt;
   rvPkg::immTypeT      immType;
   rvPkg::exCtrlT       exCtrl;
   rvPkg::wbCtrlT       wbCtrl;
   rvPkg::fwdT          fwd;
   rvPkg::pcSelT        pcSel;
   logic [31:0]         nextPc;
   logic [31:0]         rd1;
   logic [31:0]         rd2;
   logic [31:0]         aluOut;
   logic [31:0]         storeData;
   logic [3:0]          strb;
   logic [31:0]         exInst;
   logic [31:0]         exPc;
   logic [31:0]         exRs1;
   logic [31:0]         exRs2;
   logic [4:0]          wbRd;
   logic [31:0]         wbAlu;
   logic [31:0]         wbPc4;
   logic [31:0]         dramQ;
   logic [31:0]         laneWord;
   logic [31:0]         loadVal;
   logic [31:0]         wbVal;
   logic [ramIdxW-1:0]  ramIdx;
   logic [31:0]         dram [dataRamWords];

   pipeControl #(.resetPc(resetPc)) control (
      .clk(clk), .rst(rst), .stall(stall), .inst(inst), .brEq(brEq), .brLt(brLt),
      .exAddr(aluOut), .immType(immType), .exCtrl(exCtrl), .wbCtrl(wbCtrl), .fwd(fwd),
      .pcSel(pcSel), .injectNop(injectNop), .dramWe(dramWe), .ioStore(ioStore)
   );

   regFile regs (
      .clk(clk), .rs1(inst[19:15]), .rs2(inst[24:20]), .rd(wbRd),
      .we(wbCtrl.regWrEn), .wd(wbVal), .rd1(rd1), .rd2(rd2)
   );

   execUnit exec (
      .exInst(exInst), .pc(exPc), .rs1Val(exRs1), .rs2Val(exRs2), .wbVal(wbVal),
      .exCtrl(exCtrl), .immType(immType), .fwd(fwd), .aluOut(aluOut),
      .storeData(storeData), .brEq(brEq), .brLt(brLt)
   );

   mmioWriteBridge bridge (
      .clk(clk), .rst(rst), .ioStore(ioStore), .addr(aluOut), .data(storeData),
      .strb(strb), .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
      .aw(aw), .awvalid(awvalid), .w(w), .wvalid(wvalid), .bready(bready), .stall(stall)
   );

   always_comb begin
      case (pcSel)
         rvPkg::PLUS4:  nextPc = pc + 32'd4;
         rvPkg::TARGET: nextPc = {aluOut[31:1], 1'b0};
         default:       nextPc = pc;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= resetPc;
         exInst <= rvPkg::nopInst;
         wbRd   <= 5'd0;
      end else if (!stall) begin
         pc     <= nextPc;
         exInst <= injectNop ? rvPkg::nopInst : inst;
         wbRd   <= exInst[11:7];
      end
   end

   // Operand and result registers, decode operands take the writeback value
   always_ff @(posedge clk) begin
      if (!stall) begin
         exPc  <= pc;
         exRs1 <= fwd.fa1 ? wbVal : rd1;
         exRs2 <= fwd.fb1 ? wbVal : rd2;
         wbAlu <= aluOut;
         wbPc4 <= exPc + 32'd4;
      end
   end

   always_comb begin
      case (exCtrl.storeSize)
         2'b00:   strb = 4'b0001 << aluOut[1:0];
         2'b01:   strb = aluOut[1] ? 4'b1100 : 4'b0011;
         default: strb = 4'b1111;
      endcase
   end

   assign ramIdx = aluOut[ramIdxW+1:2];

   always_ff @(posedge clk) begin
      if (dramWe) begin
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               dram[ramIdx][8*b +: 8] <= storeData[8*b +: 8];
            end
         end
      end
      if (!stall) begin
         dramQ <= dram[ramIdx];
      end
   end

   assign laneWord = dramQ >> {wbAlu[1:0], 3'b000};

   always_comb begin
      case (wbCtrl.loadFunct3)
         3'b000:  loadVal = {{24{laneWord[7]}}, laneWord[7:0]};
         3'b001:  loadVal = {{16{laneWord[15]}}, laneWord[15:0]};
         3'b100:  loadVal = {24'd0, laneWord[7:0]};
         3'b101:  loadVal = {16'd0, laneWord[15:0]};
         default: loadVal = dramQ;
      endcase
      // Nothing readable in the I/O region
      if (wbAlu[31:28] == rvPkg::ioRegion) begin
         loadVal = 32'd0;
      end
   end

   always_comb begin
      case (wbCtrl.wbSel)
         rvPkg::MEM: wbVal = loadVal;
         rvPkg::PC4: wbVal = wbPc4;
         default:    wbVal = wbAlu;
      endcase
   end

endmodule

`default_nettype wire

/* test/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
   parameter int resetCycles = 2
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      rst = 1'b1;
   end

   // 20 ns period
   always #10 clk = ~clk;

   // Release reset on a falling edge after the reset cycles
   initial begin
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

/* test/writeChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module writeChecker #(
   parameter logic [31:0] resetPc   = 32'h0,
   parameter int          maxWrites = 64
) (
   input  wire               clk,
   input  wire               rst,
   input  wire  [31:0]       pc,
   input  wire rvPkg::axiAwT aw,
   input  wire               awvalid,
   input  wire               awready,
   input  wire rvPkg::axiWT  w,
   input  wire               wvalid,
   input  wire               wready,
   input  wire               bready,
   input  logic [31:0]       expAddr [maxWrites],
   input  logic [31:0]       expData [maxWrites],
   input  int                expCount,
   output int                writeCount,
   output int                errorCount
);

   logic         afterRst = 1'b0;
   logic         haveAddr = 1'b0;
   logic         haveData = 1'b0;
   logic         awHeld   = 1'b0;
   logic         wHeld    = 1'b0;
   logic [31:0]  gotAddr;
   logic [31:0]  gotData;
   logic [3:0]   gotStrb;
   rvPkg::axiAwT lastAw;
   rvPkg::axiWT  lastW;

   task automatic checkValue(input string name, input logic [31:0] expVal,
                             input logic [31:0] gotVal);
      if (gotVal !== expVal) begin
         $display("FAILED time %0t %s expected %h got %h", $time, name, expVal, gotVal);
         errorCount++;
      end
   endtask

   task automatic compareWrite();
      int errsBefore;
      errsBefore = errorCount;
      if (writeCount >= expCount) begin
         $display("Time %0t: unexpected extra I/O write to %h with data %h",
                  $time, gotAddr, gotData);
         errorCount++;
      end else begin
         checkValue("aw.addr", expAddr[writeCount], gotAddr);
         checkValue("w.data", expData[writeCount], gotData);
         // The program only stores whole words to I/O
         checkValue("w.strb", 32'h0000_000F, {28'd0, gotStrb});
         if (errorCount == errsBefore) begin
            $display("Write %0d: addr %h data %h ok", writeCount, gotAddr, gotData);
         end else begin
            $display("Write %0d: mismatch", writeCount);
         end
      end
      writeCount++;
   endtask

   always @(posedge clk) begin
      if (rst) begin
         writeCount = 0;
         errorCount = 0;
         haveAddr   = 1'b0;
         haveData   = 1'b0;
         awHeld     = 1'b0;
         wHeld      = 1'b0;
      end
      // Outputs during reset and on the first edge after it
      if (afterRst) begin
         checkValue("pc", resetPc, pc);
         checkValue("awvalid", 32'd0, {31'd0, awvalid});
         checkValue("wvalid", 32'd0, {31'd0, wvalid});
         checkValue("bready", 32'd0, {31'd0, bready});
         if (!rst) begin
            $display("Reset test done with %0d mismatches", errorCount);
         end
      end
      afterRst = rst;

      if (!rst) begin
         if (awHeld && (!awvalid || aw != lastAw)) begin
            $display("Time %0t: write address dropped or changed before awready", $time);
            errorCount++;
         end
         if (wHeld && (!wvalid || w != lastW)) begin
            $display("Time %0t: write data dropped or changed before wready", $time);
            errorCount++;
         end
         awHeld = awvalid && !awready;
         wHeld  = wvalid && !wready;
         lastAw = aw;
         lastW  = w;

         if (awvalid && awready) begin
            gotAddr  = aw.addr;
            haveAddr = 1'b1;
         end
         if (wvalid && wready) begin
            gotData  = w.data;
            gotStrb  = w.strb;
            haveData = 1'b1;
         end
         // Address and data may be accepted in either order
         if (haveAddr && haveData) begin
            compareWrite();
            haveAddr = 1'b0;
            haveData = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* test/tbCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tbCore;

   localparam logic [31:0] resetPc       = 32'h0;
   localparam int          maxWrites     = 64;
   localparam int          stimWords     = 512;
   localparam int          timeoutCycles = 5000;
   localparam int          drainCycles   = 40;

   logic         clk;
   logic         rst;
   logic [31:0]  pc;
   logic [31:0]  inst;
   rvPkg::axiAwT aw;
   logic         awvalid;
   logic         awready;
   rvPkg::axiWT  w;
   logic         wvalid;
   logic         wready;
   logic         bvalid;
   logic [1:0]   bresp;
   logic         bready;
   logic [31:0]  stim [stimWords];
   logic [31:0]  expAddr [maxWrites];
   logic [31:0]  expData [maxWrites];
   int           progLen = 0;
   int           expCount = 0;
   int           writeCount;
   int           errorCount;
   int           awWait;
   int           wWait;
   int           bWait;
   logic         timedOut = 1'b0;

   clockGen clocks (.clk(clk), .rst(rst));

   rvCore #(.resetPc(resetPc), .dataRamWords(256)) dut (
      .clk(clk), .rst(rst), .inst(inst), .pc(pc), .aw(aw), .awvalid(awvalid),
      .awready(awready), .w(w), .wvalid(wvalid), .wready(wready), .bvalid(bvalid),
      .bresp(bresp), .bready(bready)
   );

   writeChecker #(.resetPc(resetPc), .maxWrites(maxWrites)) scoreboard (
      .clk(clk), .rst(rst), .pc(pc), .aw(aw), .awvalid(awvalid), .awready(awready),
      .w(w), .wvalid(wvalid), .wready(wready), .bready(bready), .expAddr(expAddr),
      .expData(expData), .expCount(expCount), .writeCount(writeCount),
      .errorCount(errorCount)
   );

   // Instruction memory, nop past the end of the program
   always_comb begin
      int idx;
      idx = int'(pc[31:2]);
      if (idx < progLen) begin
         inst = stim[2 + idx];
      end else begin
         inst = rvPkg::nopInst;
      end
   end

   // AXI slave side, each ready or response held back 0 to 3 cycles
   initial begin
      void'($urandom(32'h6f388589));
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      bresp   = 2'b00;
      awWait  = int'($urandom % 4);
      wWait   = int'($urandom % 4);
      bWait   = int'($urandom % 4);
      for (int c = 0; c < timeoutCycles + drainCycles + 50; c++) begin
         @(negedge clk);
         if (awready) begin
            awready = 1'b0;
            awWait  = int'($urandom % 4);
         end else if (awvalid && !rst) begin
            if (awWait == 0) awready = 1'b1;
            else awWait--;
         end
         if (wready) begin
            wready = 1'b0;
            wWait  = int'($urandom % 4);
         end else if (wvalid && !rst) begin
            if (wWait == 0) wready = 1'b1;
            else wWait--;
         end
         if (bvalid) begin
            bvalid = 1'b0;
            bWait  = int'($urandom % 4);
         end else if (bready && !rst) begin
            if (bWait == 0) bvalid = 1'b1;
            else bWait--;
         end
      end
   end

   initial begin
      int cycles;
      $readmemh("test/core_stimulus.txt", stim);
      progLen  = int'(stim[0]);
      expCount = int'(stim[1]);
      for (int i = 0; i < expCount && i < maxWrites; i++) begin
         expAddr[i] = stim[2 + progLen + 2 * i];
         expData[i] = stim[3 + progLen + 2 * i];
      end

      cycles = 0;
      while (rst && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (rst) begin
         timedOut = 1'b1;
         $display("Timeout: reset never released");
      end

      cycles = 0;
      while (!timedOut && writeCount < expCount && cycles < timeoutCycles) begin
         @(negedge clk);
         cycles++;
      end
      if (!timedOut && writeCount < expCount) begin
         timedOut = 1'b1;
         $display("Timeout: only %0d of %0d I/O writes arrived in %0d cycles",
                  writeCount, expCount, timeoutCycles);
      end

      // Let any stray extra write show up
      for (cycles = 0; cycles < drainCycles && !timedOut; cycles++) begin
         @(negedge clk);
      end

      $display("Summary: %0d of %0d writes seen, %0d errors", writeCount, expCount,
               errorCount);
      if (!timedOut && errorCount == 0 && writeCount == expCount) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/core_stimulus.txt */
// Header: program length, expected write count
// Then program words, then expected I/O write address and data pairs
00000047 0000000F
// lui x1 base, addi, add, sub, slt, sltu, shifts, xor with stores
800000B7 06400113 FF900193 00310233
0040A023 403102B3 0050A223 0021A333
003133B3 00431413 00746433 0080A423
4011D493 01C1D513 00A4C5B3 00B0A623
// auipc, write to x0 then read x0
00001617 00C0A823 00510013 002006B3 00D0AA23
// Branches, taken then not taken for each
00000713
00210463 00170713 00310463 04070713
00311463 00170713 00211463 04070713
0021C463 00170713 00314463 04070713
00315463 00170713 0021D463 04070713
00316463 00170713 0021E463 04070713
0021F463 00170713 00317463 04070713
00E0AC23
// jal and jalr with link values
00C007EF 00170713 00170713 00F0AE23
01878867 00170713 00170713 0300A023 02E0A223
// Data RAM stores and loads
87654937 3F190913 05202023 042000A3 04301123
04000983 04104A03 04201A83 04005B03 04002B83
0330A423 0340A623 0350A823 0360AA23 0370AC23
// Expected writes
80000000 0000005D
80000004 0000006B
80000008 00000011
8000000C FFFFFFF3
80000010 00001040
80000014 00000064
80000018 00000180
8000001C 000000C0
80000020 000000D0
80000024 00000180
80000028 FFFFFFF1
8000002C 00000064
80000030 FFFFFFF9
80000034 000064F1
80000038 FFF964F1

/* project.f */
rtl/rvPkg.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/pipeControl.sv
rtl/mmioWriteBridge.sv
rtl/rvCore.sv
test/clockGen.sv
test/writeChecker.sv
test/tbCore.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tbCore -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
   exit 1
fi
exit 0
